//--- Bender.yml
package:
  name: dcache_data_array

sources:
  # Package and interface first, then the blocks and the top level
  - files:
      - rtl/dcache_pkg.sv
      - rtl/dcache_port_if.sv
      - rtl/data_memory_bank.sv
      - rtl/data_cache_block.sv
      - rtl/apb_store_port.sv
      - rtl/apb_load_port.sv
      - rtl/dcache_data_array_top.sv

  # Testbench top is tb_dcache_data_array
  - target: test
    files:
      - testbench/tb_dcache_data_array.sv

//--- flist.f
rtl/dcache_pkg.sv
rtl/dcache_port_if.sv
rtl/data_memory_bank.sv
rtl/data_cache_block.sv
rtl/apb_store_port.sv
rtl/apb_load_port.sv
rtl/dcache_data_array_top.sv
testbench/tb_dcache_data_array.sv

//--- rtl/apb_load_port.sv
// APB read slave that issues array loads and completes after the bank latency
`timescale 1ns/1ps
`default_nettype none

module apb_load_port (
    input  logic                                 clk_i,
    input  logic                                 rst_i,

    // APB slave side, read-only bus
    input  logic                                 psel_i,
    input  logic                                 penable_i,
    input  logic [dcache_pkg::APB_ADDR_WIDTH-1:0] paddr_i,
    output logic                                 pready_o,
    output logic [dcache_pkg::PORT_WIDTH-1:0]     prdata_o,
    output logic                                 pslverr_o,

    // Request side of the array read-only port
    dcache_port_if.requester                     mem_o
);

    import dcache_pkg::*;

    // ------------------------------------------------
    // Access tracking
    // ------------------------------------------------

    logic access;
    logic aligned;

    // Set during the second access cycle, when the bank data is ready
    logic pending_q;

    // Alignment error of the transfer in flight
    logic error_q;

    assign access  = psel_i & penable_i;
    assign aligned = (paddr_i[BYTE_OFFSET-1:0] == '0);

    // The first access cycle arms the flag and the second clears it,
    // so each access phase lasts exactly two cycles
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pending_q <= 1'b0;
            error_q   <= 1'b0;
        end else begin
            pending_q <= access & ~pending_q;
            if (access & ~pending_q) begin
                error_q <= ~aligned;
            end
        end
    end

    // ------------------------------------------------
    // Array request and response
    // ------------------------------------------------

    assign mem_o.chip_select = paddr_i[CHIP_LSB +: CHIP_ADDR];
    assign mem_o.address     = paddr_i[INDEX_LSB +: ADDR_WIDTH];

    // Load only in the first access cycle and never for a bad address
    assign mem_o.read = access & ~pending_q & aligned;

    // Store signals stay inactive on the load side
    assign mem_o.write      = 1'b0;
    assign mem_o.wdata      = '0;
    assign mem_o.byte_write = '0;

    // Completion in the second cycle with the registered bank word
    assign pready_o  = access & pending_q;
    assign pslverr_o = pready_o & error_q;

    // Error responses and idle cycles return zero data
    assign prdata_o = (pready_o & ~error_q) ? mem_o.rdata : '0;

    // The master keeps the access phase and its address until the
    // second cycle completes the transfer
    two_cycle_access : assert property (
        @(posedge clk_i) disable iff (rst_i)
        pending_q |-> psel_i && penable_i && $stable(paddr_i)
    );

endmodule : apb_load_port

`default_nettype wire

//--- rtl/apb_store_port.sv
// APB write slave that turns store transfers into byte-strobed array writes
`timescale 1ns/1ps
`default_nettype none

module apb_store_port (
    input  logic                                 clk_i,
    input  logic                                 rst_i,

    // APB slave side, write-only bus
    input  logic                                 psel_i,
    input  logic                                 penable_i,
    input  logic                                 pwrite_i,
    input  logic [dcache_pkg::APB_ADDR_WIDTH-1:0] paddr_i,
    input  logic [dcache_pkg::PORT_WIDTH-1:0]     pwdata_i,
    input  logic [dcache_pkg::PORT_BYTES-1:0]     pstrb_i,
    output logic                                 pready_o,
    output logic                                 pslverr_o,

    // Request side of the array read/write port
    dcache_port_if.requester                     mem_o
);

    import dcache_pkg::*;

    // ------------------------------------------------
    // Transfer decode
    // ------------------------------------------------

    // Access phase of the current transfer
    logic access;

    // Word-aligned byte address
    logic aligned;

    // Transfer to be answered with an error and no write
    logic error;

    assign access  = psel_i & penable_i;
    assign aligned = (paddr_i[BYTE_OFFSET-1:0] == '0);

    // Reads are not served on this bus and neither are unaligned stores
    assign error = ~aligned | ~pwrite_i;

    // Zero wait states, every access phase completes at once
    assign pready_o  = access;
    assign pslverr_o = access & error;

    // ------------------------------------------------
    // Array request
    // ------------------------------------------------

    // Bank select from the low word bits, index from the upper bits
    assign mem_o.chip_select = paddr_i[CHIP_LSB +: CHIP_ADDR];
    assign mem_o.address     = paddr_i[INDEX_LSB +: ADDR_WIDTH];
    assign mem_o.wdata       = pwdata_i;
    assign mem_o.byte_write  = pstrb_i;

    // The write commits on the completing edge of the access phase
    assign mem_o.write = access & ~error;

    // This port never loads
    assign mem_o.read = 1'b0;

    // An access phase is always preceded by a setup cycle
    setup_before_access : assert property (
        @(posedge clk_i) disable iff (rst_i)
        $rose(penable_i) |-> $past(psel_i)
    );

endmodule : apb_store_port

`default_nettype wire

//--- rtl/data_cache_block.sv
// Bank select decode, banked data storage and registered read data mux
`timescale 1ns/1ps
`default_nettype none

module data_cache_block (
    input  logic          clk_i,

    // Port 0 carries stores, port 1 carries loads
    dcache_port_if.memory port0_i,
    dcache_port_if.memory port1_i
);

    import dcache_pkg::*;

    // ------------------------------------------------
    // Bank select decode
    // ------------------------------------------------

    // One-hot bank enables, one vector per port
    logic [CACHE_CHIP-1:0] port0_enable;
    logic [CACHE_CHIP-1:0] port1_enable;

    // Enables already qualified by the access strobe
    logic [CACHE_CHIP-1:0] bank_write;
    logic [CACHE_CHIP-1:0] bank_read;

    // A select that is not a known value enables no bank at all
    always_comb begin
        port0_enable = '0;
        port1_enable = '0;
        for (int i = 0; i < CACHE_CHIP; i++) begin
            if (port0_i.chip_select == CHIP_ADDR'(i)) begin
                port0_enable[i] = 1'b1;
            end
            if (port1_i.chip_select == CHIP_ADDR'(i)) begin
                port1_enable[i] = 1'b1;
            end
        end
    end

    // Only the addressed bank sees a strobe, the rest stay idle
    assign bank_write = port0_enable & {CACHE_CHIP{port0_i.write}};
    assign bank_read  = port1_enable & {CACHE_CHIP{port1_i.read}};

    // ------------------------------------------------
    // Banks
    // ------------------------------------------------

    // Registered output word of every bank
    logic [CACHE_CHIP-1:0][PORT_WIDTH-1:0] bank_rdata;

    // Address and data fan out to all banks, the strobe picks one
    for (genvar i = 0; i < CACHE_CHIP; i++) begin : gen_bank
        data_memory_bank bank (
            .clk_i              ( clk_i              ),
            .port0_byte_write_i ( port0_i.byte_write ),
            .port0_address_i    ( port0_i.address    ),
            .port0_data_i       ( port0_i.wdata      ),
            .port0_write_i      ( bank_write[i]      ),
            .port1_address_i    ( port1_i.address    ),
            .port1_data_o       ( bank_rdata[i]      ),
            .port1_read_i       ( bank_read[i]       )
        );
    end : gen_bank

    // ------------------------------------------------
    // Read data mux
    // ------------------------------------------------

    // Bank outputs arrive one cycle after the request, so the select
    // of that request is kept until the data is muxed out
    logic [CHIP_ADDR-1:0] port1_select_q;

    always_ff @(posedge clk_i) begin
        if (port1_i.read) begin
            port1_select_q <= port1_i.chip_select;
        end
    end

    assign port1_i.rdata = bank_rdata[port1_select_q];

    // The store port has no read data path
    assign port0_i.rdata = '0;

    // A strobe must reach exactly one bank
    // An unknown select would enable none and the access would be lost
    bank_enable_onehot : assert property (
        @(posedge clk_i)
        (!port0_i.write || $onehot(bank_write)) &&
        (!port1_i.read || $onehot(bank_read))
    );

    // The store side never reads and the load side never writes
    port_direction : assert property (
        @(posedge clk_i) !port0_i.read && !port1_i.write
    );

endmodule : data_cache_block

`default_nettype wire

//--- rtl/data_memory_bank.sv
// Single 32-bit data bank with a byte-write port and a registered read port
`timescale 1ns/1ps
`default_nettype none

module data_memory_bank (
    input  logic                             clk_i,

    // Port 0 writes the word lanes selected by the byte strobes
    input  logic [dcache_pkg::PORT_BYTES-1:0] port0_byte_write_i,
    input  logic [dcache_pkg::ADDR_WIDTH-1:0] port0_address_i,
    input  logic [dcache_pkg::PORT_WIDTH-1:0] port0_data_i,
    input  logic                             port0_write_i,

    // Port 1 reads one word with one cycle of latency
    input  logic [dcache_pkg::ADDR_WIDTH-1:0] port1_address_i,
    output logic [dcache_pkg::PORT_WIDTH-1:0] port1_data_o,
    input  logic                             port1_read_i
);

    import dcache_pkg::*;

    // Storage is left uninitialised, a word is unknown until written
    logic [PORT_WIDTH-1:0] memory [BANK_DEPTH];

    // ------------------------------------------------
    // Write port
    // ------------------------------------------------

    // Each lane is updated on its own so that byte and halfword stores
    // leave the other lanes of the word untouched
    always_ff @(posedge clk_i) begin
        if (port0_write_i) begin
            for (int b = 0; b < PORT_BYTES; b++) begin
                if (port0_byte_write_i[b]) begin
                    memory[port0_address_i][b*BYTE_WIDTH +: BYTE_WIDTH] <=
                        port0_data_i[b*BYTE_WIDTH +: BYTE_WIDTH];
                end
            end
        end
    end

    // ------------------------------------------------
    // Read port
    // ------------------------------------------------

    // The word is sampled before a write on the same edge lands,
    // so a colliding read returns the old contents
    // The output holds its last value while no read is active
    always_ff @(posedge clk_i) begin
        if (port1_read_i) begin
            port1_data_o <= memory[port1_address_i];
        end
    end

    // A read with an unknown index would load garbage into the output
    // register and hand it to the load port on the next cycle
    read_address_known : assert property (
        @(posedge clk_i) port1_read_i |-> !$isunknown(port1_address_i)
    );

endmodule : data_memory_bank

`default_nettype wire

//--- rtl/dcache_data_array_top.sv
// Top level of the banked data array with one APB store bus and one APB load bus
`timescale 1ns/1ps
`default_nettype none

module dcache_data_array_top (
    input  logic                                 clk_i,
    input  logic                                 rst_i,

    // Write bus
    input  logic                                 psel_w_i,
    input  logic                                 penable_w_i,
    input  logic                                 pwrite_w_i,
    input  logic [dcache_pkg::APB_ADDR_WIDTH-1:0] paddr_w_i,
    input  logic [dcache_pkg::PORT_WIDTH-1:0]     pwdata_w_i,
    input  logic [dcache_pkg::PORT_BYTES-1:0]     pstrb_w_i,
    output logic                                 pready_w_o,
    output logic                                 pslverr_w_o,

    // Read bus
    input  logic                                 psel_r_i,
    input  logic                                 penable_r_i,
    input  logic [dcache_pkg::APB_ADDR_WIDTH-1:0] paddr_r_i,
    output logic                                 pready_r_o,
    output logic [dcache_pkg::PORT_WIDTH-1:0]     prdata_r_o,
    output logic                                 pslverr_r_o
);

    // Store traffic into the read/write port of the array
    dcache_port_if wr_port ();

    // Load traffic into the read-only port of the array
    dcache_port_if rd_port ();

    apb_store_port store_port0 (
        .clk_i     ( clk_i       ),
        .rst_i     ( rst_i       ),
        .psel_i    ( psel_w_i    ),
        .penable_i ( penable_w_i ),
        .pwrite_i  ( pwrite_w_i  ),
        .paddr_i   ( paddr_w_i   ),
        .pwdata_i  ( pwdata_w_i  ),
        .pstrb_i   ( pstrb_w_i   ),
        .pready_o  ( pready_w_o  ),
        .pslverr_o ( pslverr_w_o ),
        .mem_o     ( wr_port     )
    );

    // Both buses reach the banks at the same time
    data_cache_block array0 (
        .clk_i   ( clk_i   ),
        .port0_i ( wr_port ),
        .port1_i ( rd_port )
    );

    apb_load_port load_port0 (
        .clk_i     ( clk_i       ),
        .rst_i     ( rst_i       ),
        .psel_i    ( psel_r_i    ),
        .penable_i ( penable_r_i ),
        .paddr_i   ( paddr_r_i   ),
        .pready_o  ( pready_r_o  ),
        .prdata_o  ( prdata_r_o  ),
        .pslverr_o ( pslverr_r_o ),
        .mem_o     ( rd_port     )
    );

endmodule : dcache_data_array_top

`default_nettype wire

//--- rtl/dcache_pkg.sv
// Data word format, banked array geometry and APB address split constants
`default_nettype none

package dcache_pkg;

    // ------------------------------------------------
    // Data word format
    // ------------------------------------------------

    // Width of one data word, matching the RV32 register width
    localparam int PORT_WIDTH = 32;

    // Width of one byte lane inside the word
    localparam int BYTE_WIDTH = 8;

    // Byte lanes per word, one write strobe bit for each
    localparam int PORT_BYTES = PORT_WIDTH / BYTE_WIDTH;

    // ------------------------------------------------
    // Array geometry
    // ------------------------------------------------

    // Number of 32-bit banks that make up the data array
    localparam int CACHE_CHIP = 4;

    // Bits that pick one bank out of CACHE_CHIP
    localparam int CHIP_ADDR = $clog2(CACHE_CHIP);

    // Word index inside one bank
    localparam int ADDR_WIDTH = 6;

    // Words held by each bank
    localparam int BANK_DEPTH = 2 ** ADDR_WIDTH;

    // ------------------------------------------------
    // APB byte address split
    // ------------------------------------------------

    // Byte offset bits at the bottom of the address, zero on an aligned access
    localparam int BYTE_OFFSET = $clog2(PORT_BYTES);

    // The bank select sits right above the byte offset so that
    // consecutive words land in consecutive banks
    localparam int CHIP_LSB = BYTE_OFFSET;

    // The word index inside the bank takes the remaining upper bits
    localparam int INDEX_LSB = BYTE_OFFSET + CHIP_ADDR;

    // Full byte address width seen on both APB buses (1 KiB window)
    localparam int APB_ADDR_WIDTH = BYTE_OFFSET + CHIP_ADDR + ADDR_WIDTH;

endpackage : dcache_pkg

`default_nettype wire

//--- rtl/dcache_port_if.sv
// Request and response bundle for one data array port, with requester and memory modports
`timescale 1ns/1ps
`default_nettype none

interface dcache_port_if;

    import dcache_pkg::*;

    // Bank picked by the low word-address bits
    logic [CHIP_ADDR-1:0]  chip_select;

    // Word index inside the selected bank
    logic [ADDR_WIDTH-1:0] address;

    // Store data and its byte lane enables
    logic [PORT_WIDTH-1:0] wdata;
    logic [PORT_BYTES-1:0] byte_write;

    // Single-cycle access strobes
    logic                  write;
    logic                  read;

    // Word from the bank, valid one cycle after read
    logic [PORT_WIDTH-1:0] rdata;

    // The bus side drives the request and waits for the data
    modport requester (
        output chip_select, address, wdata, byte_write, write, read,
        input  rdata
    );

    // The array side only answers with read data
    modport memory (
        input  chip_select, address, wdata, byte_write, write, read,
        output rdata
    );

endinterface : dcache_port_if

`default_nettype wire

//--- testbench/tb_dcache_data_array.sv
// Testbench with clock, reset, APB drivers, LCG, reference memory, checker and watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_dcache_data_array;

    import dcache_pkg::*;

    // Transfer counts of each test phase
    localparam int N_PART   = 200;
    localparam int N_UNAL   = 16;
    localparam int N_CONC   = 300;
    localparam int N_COLL   = 8;
    localparam int N_WORDS  = CACHE_CHIP * BANK_DEPTH;
    localparam int RST_CYC  = 10;
    localparam int N_XFERS  = 2 * N_WORDS + 2 * N_PART + 4 * N_UNAL + 2 * N_CONC + 2 * N_COLL;
    // A read takes four cycles with the idle gap, a write three
    localparam int CYCLE_LIMIT = N_XFERS * 4 + RST_CYC + 200;

    logic clk_i;
    logic rst_i;
    logic psel_w_i, penable_w_i, pwrite_w_i, pready_w_o, pslverr_w_o;
    logic [APB_ADDR_WIDTH-1:0] paddr_w_i, paddr_r_i;
    logic [PORT_WIDTH-1:0] pwdata_w_i, prdata_r_o;
    logic [PORT_BYTES-1:0] pstrb_w_i;
    logic psel_r_i, penable_r_i, pready_r_o, pslverr_r_o;

    // Byte-wide reference memory and a written flag for every word
    logic [7:0] ref_mem [1 << APB_ADDR_WIDTH];
    logic written [N_WORDS];

    // State of the checker between the two read access cycles
    logic rd_issued;
    logic [APB_ADDR_WIDTH-1:0] rd_addr;
    logic [PORT_WIDTH:0] rd_expect;
    logic rd_known;
    logic wr_err;
    int base;

    int value_errors, protocol_errors, reads_checked, writes_checked;
    int cycle_count;
    logic [31:0] lcg_state;
    logic [31:0] r;

    // Stimulus of the concurrent phase, drawn before both buses start
    logic [APB_ADDR_WIDTH-1:0] conc_wr_addr [N_CONC];
    logic [APB_ADDR_WIDTH-1:0] conc_rd_addr [N_CONC];
    logic [PORT_WIDTH-1:0] conc_data [N_CONC];
    logic [PORT_BYTES-1:0] conc_strb [N_CONC];

    dcache_data_array_top dut0 (.*);

    always #4 clk_i = ~clk_i;

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [APB_ADDR_WIDTH-1:0] word_addr(input int w);
        return APB_ADDR_WIDTH'(w * PORT_BYTES);
    endfunction

    // Expected {pslverr, prdata}; unaligned loads give an error with zero data
    function automatic logic [PORT_WIDTH:0] ref_read(input logic [APB_ADDR_WIDTH-1:0] addr);
        logic [PORT_WIDTH-1:0] word;
        int wbase;
        wbase = int'(addr) & ~(PORT_BYTES - 1);
        if (addr[BYTE_OFFSET-1:0] != '0) begin
            return {1'b1, {PORT_WIDTH{1'b0}}};
        end
        for (int b = 0; b < PORT_BYTES; b++) begin
            word[b*8 +: 8] = ref_mem[wbase + b];
        end
        return {1'b0, word};
    endfunction

    // Setup cycle, access phase, then wait for pready on the write bus
    task automatic write_xfer(input logic [APB_ADDR_WIDTH-1:0] addr,
                              input logic [PORT_WIDTH-1:0] data,
                              input logic [PORT_BYTES-1:0] strb, input logic wr);
        @(posedge clk_i);
        psel_w_i    <= 1'b1;
        penable_w_i <= 1'b0;
        pwrite_w_i  <= wr;
        paddr_w_i   <= addr;
        pwdata_w_i  <= data;
        pstrb_w_i   <= strb;
        @(posedge clk_i);
        penable_w_i <= 1'b1;
        @(posedge clk_i);
        while (!pready_w_o) @(posedge clk_i);
        psel_w_i    <= 1'b0;
        penable_w_i <= 1'b0;
    endtask

    task automatic read_xfer(input logic [APB_ADDR_WIDTH-1:0] addr);
        @(posedge clk_i);
        psel_r_i    <= 1'b1;
        penable_r_i <= 1'b0;
        paddr_r_i   <= addr;
        @(posedge clk_i);
        penable_r_i <= 1'b1;
        @(posedge clk_i);
        while (!pready_r_o) @(posedge clk_i);
        psel_r_i    <= 1'b0;
        penable_r_i <= 1'b0;
    endtask

    // --------------------------------------------------
    // Checker and reference model update
    // --------------------------------------------------

    // A read issued on an edge samples the model before a write completing
    // on the same edge is applied, as the banks do
    always @(posedge clk_i) begin
        if (!rst_i && psel_r_i && penable_r_i) begin
            if (!pready_r_o) begin
                if (rd_issued) begin
                    protocol_errors++;
                    $display("Read at %0t did not complete in its second access cycle", $time);
                end
                rd_issued = 1'b1;
                rd_addr   = paddr_r_i;
                rd_expect = ref_read(paddr_r_i);
                rd_known  = written[paddr_r_i[APB_ADDR_WIDTH-1:BYTE_OFFSET]];
            end else if (!rd_issued) begin
                protocol_errors++;
                $display("Read at %0t completed in its first access cycle", $time);
            end else begin
                reads_checked++;
                rd_issued = 1'b0;
                if (pslverr_r_o !== rd_expect[PORT_WIDTH] ||
                    ((rd_known || rd_expect[PORT_WIDTH]) &&
                     prdata_r_o !== rd_expect[PORT_WIDTH-1:0])) begin
                    value_errors++;
                    $display("Mismatch at %0t: read %h got %h err %b, expected %h err %b",
                             $time, rd_addr, prdata_r_o, pslverr_r_o,
                             rd_expect[PORT_WIDTH-1:0], rd_expect[PORT_WIDTH]);
                end
            end
        end
        if (!rst_i && psel_w_i && penable_w_i) begin
            if (!pready_w_o) begin
                protocol_errors++;
                $display("Write bus inserted a wait state at %0t", $time);
            end else begin
                writes_checked++;
                wr_err = (paddr_w_i[BYTE_OFFSET-1:0] != '0) || !pwrite_w_i;
                if (pslverr_w_o !== wr_err) begin
                    value_errors++;
                    $display("Mismatch at %0t: write %h pslverr %b, expected %b",
                             $time, paddr_w_i, pslverr_w_o, wr_err);
                end
                // Only completed aligned stores reach memory, lane by lane
                if (!wr_err) begin
                    base = int'(paddr_w_i);
                    for (int b = 0; b < PORT_BYTES; b++) begin
                        if (pstrb_w_i[b]) ref_mem[base + b] = pwdata_w_i[b*8 +: 8];
                    end
                    written[paddr_w_i[APB_ADDR_WIDTH-1:BYTE_OFFSET]] = 1'b1;
                end
            end
        end
    end

    // Watchdog ends a hung run
    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, a transfer never completed", cycle_count);
        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
        $display("SIMULATION FAILED");
        $finish;
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------

    initial begin
        clk_i = 1'b0;
        rst_i = 1'b1;
        {psel_w_i, penable_w_i, pwrite_w_i, psel_r_i, penable_r_i} = '0;
        paddr_w_i = '0;
        pwdata_w_i = '0;
        pstrb_w_i = '0;
        paddr_r_i = '0;
        {value_errors, protocol_errors, reads_checked, writes_checked} = '0;
        rd_issued = 1'b0;
        lcg_state = 32'd64666;
        for (int w = 0; w < N_WORDS; w++) written[w] = 1'b0;
        repeat (RST_CYC) @(posedge clk_i);
        rst_i <= 1'b0;
        @(posedge clk_i);
        if (pready_w_o !== 1'b0 || pready_r_o !== 1'b0 ||
            pslverr_w_o !== 1'b0 || pslverr_r_o !== 1'b0) begin
            value_errors++;
            $display("Mismatch at %0t: outputs not idle after reset", $time);
        end
        // Full words to every bank and index, then read all back
        for (int w = 0; w < N_WORDS; w++) write_xfer(word_addr(w), next_rand(), '1, 1'b1);
        for (int w = 0; w < N_WORDS; w++) read_xfer(word_addr(w));
        // Byte-strobed stores merged into existing words
        for (int i = 0; i < N_PART; i++) begin
            r = next_rand();
            write_xfer(word_addr(r[23:16]), next_rand(), r[11:8], 1'b1);
            read_xfer(word_addr(r[23:16]));
        end
        // Unaligned and read-direction transfers leave memory untouched
        for (int i = 0; i < N_UNAL; i++) begin
            r = next_rand();
            write_xfer(word_addr(r[23:16]) | (r[1:0] | 2'b01), next_rand(), '1, 1'b1);
            write_xfer(word_addr(r[23:16]), next_rand(), '1, 1'b0);
            read_xfer(word_addr(r[23:16]) | 2'b10);
            read_xfer(word_addr(r[23:16]));
        end
        // Write completion and read issue fall on the same edge
        for (int i = 0; i < N_COLL; i++) begin
            r = next_rand();
            fork
                write_xfer(word_addr(r[23:16]), next_rand(), '1, 1'b1);
                read_xfer(word_addr(r[23:16]));
            join
        end
        // Both buses busy at once over a few words to provoke collisions
        for (int i = 0; i < N_CONC; i++) begin
            r = next_rand();
            conc_wr_addr[i] = word_addr(r[18:16]);
            conc_rd_addr[i] = word_addr(r[22:20]);
            conc_strb[i]    = r[11:8];
            conc_data[i]    = next_rand();
        end
        fork
            for (int k = 0; k < N_CONC; k++) begin
                write_xfer(conc_wr_addr[k], conc_data[k], conc_strb[k], 1'b1);
            end
            for (int k = 0; k < N_CONC; k++) read_xfer(conc_rd_addr[k]);
        join
        repeat (2) @(posedge clk_i);
        $display("Checked %0d reads and %0d writes: %0d value errors, %0d protocol errors",
                 reads_checked, writes_checked, value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule : tb_dcache_data_array

`default_nettype wire
